//--- flist.f
verilog/dspPkg.sv
verilog/dspCtrl.sv
verilog/preAdder.sv
verilog/multStage.sv
verilog/operandMux.sv
verilog/dspAlu.sv
verilog/dspSlice.sv
dv/dspSlice_chk.sv
dv/dspSliceTb.sv

//--- dv/dspSliceTb.sv
`timescale 1ns/1ps
`default_nettype none

module dspSliceTb;

   // 10 reset cycles, 6 x 300 operations and a short drain.
   localparam int cycleLimit = 2500;

   logic                          CLK = 1'b0;
   logic                          rstN;
   logic [dspPkg::aWidth-1:0]     a;
   logic [dspPkg::bWidth-1:0]     b;
   logic [dspPkg::cWidth-1:0]     c;
   logic [dspPkg::dWidth-1:0]     d;
   logic [dspPkg::pWidth-1:0]     pcIn;
   logic [2:0]                    inMode;
   logic [6:0]                    opMode;
   logic [3:0]                    aluMode;
   logic                          carryIn, ceA, ceB, ceC, ceD, ceM, ceP, ceCtrl;
   wire  [dspPkg::pWidth-1:0]     p;
   wire                           carryOut, patternDetect, patternBDetect, opModeInvalid;

   // model registers.
   logic [29:0] mA;
   logic [17:0] mB;
   logic [24:0] mD;
   logic [42:0] mM;
   logic [47:0] mC, mP;
   logic [2:0]  mInMode;
   logic [6:0]  mOpMode;
   logic [3:0]  mAlu;
   logic        mCarryIn, mCarryOut, mPat, mPatB, mPValid;
   int          cycles = 0;

   // second-stage fields wait one cycle, pcIn waits two.
   logic [47:0] nextC, pcInMid, pcInLate;
   logic [6:0]  nextOpMode;
   logic [3:0]  nextAlu;
   logic        nextCarry;

   dspSlice DUT (.*);

   always #2 CLK = ~CLK;

   function automatic logic [47:0] rand48();
      return 48'({$urandom(), $urandom()});
   endfunction

   // d when enabled, a unless gated, minus only with both present.
   function automatic logic [24:0] preModel(input logic [29:0] aR, input logic [24:0] dR,
                                            input logic [2:0] im);
      logic [24:0] dPart;
      logic [24:0] aPart;
      dPart = im[1] ? dR : 25'd0;
      aPart = im[0] ? 25'd0 : aR[24:0];
      if (im[2] && im[1] && !im[0])
         return dPart - aPart;
      return dPart + aPart;
   endfunction

   function automatic logic [42:0] prodModel(input logic [24:0] pa, input logic [17:0] pb);
      logic [42:0] ea;
      logic [42:0] eb;
      ea = {{18{pa[24]}}, pa};
      eb = {{25{pb[17]}}, pb};
      return ea * eb;
   endfunction

   function automatic logic [47:0] shiftModel(input logic [47:0] v);
      return {{dspPkg::zShift{v[47]}}, v[47:dspPkg::zShift]};
   endfunction

   task automatic checkValue(input string name, input logic [47:0] got, input logic [47:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   always @(posedge CLK) begin : model
      logic [47:0] xv, yv, zv, res;
      logic [49:0] sumAdd, sumSub;
      logic        carry;
      if (!rstN) begin
         {mA, mB, mD, mM, mC, mP} = '0;
         {mInMode, mOpMode, mAlu, mCarryIn, mCarryOut, mPat, mPatB} = '0;
         mPValid = 1'b1;
      end else begin
         case (mOpMode[1:0])
            dspPkg::xMult: xv = {{5{mM[42]}}, mM};
            dspPkg::xP:    xv = mP;
            dspPkg::xAB:   xv = {mA, mB};
            default:       xv = '0;
         endcase
         yv = (mOpMode[3:2] == dspPkg::yOnes) ? '1 : (mOpMode[3:2] == dspPkg::yC) ? mC : '0;
         case (mOpMode[6:4])
            dspPkg::zPcIn:      zv = pcIn;
            dspPkg::zP:         zv = mP;
            dspPkg::zC:         zv = mC;
            dspPkg::zPcInShift: zv = shiftModel(pcIn);
            dspPkg::zPShift:    zv = shiftModel(mP);
            default:            zv = '0;
         endcase
         sumAdd = {2'b0, zv} + {2'b0, xv} + {2'b0, yv} + {49'd0, mCarryIn};
         sumSub = {2'b0, zv} - ({2'b0, xv} + {2'b0, yv} + {49'd0, mCarryIn});
         carry = 1'b0;
         case (mAlu)
            dspPkg::aluZMinus: begin
               res = sumSub[47:0];
               carry = sumSub[48];
            end
            dspPkg::aluXor: res = xv ^ zv;
            dspPkg::aluAnd: res = xv & zv;
            dspPkg::aluOr:  res = xv | zv;
            default: begin
               res = sumAdd[47:0];
               carry = sumAdd[48];
            end
         endcase
         if (ceP) begin
            mP = res;
            mCarryOut = carry;
            mPat = (res | dspPkg::patternMask) == (mC | dspPkg::patternMask);
            mPatB = (res | dspPkg::patternMask) == (~mC | dspPkg::patternMask);
            mPValid = (mOpMode[1:0] == dspPkg::xMult) == (mOpMode[3:2] == dspPkg::yMult);
         end
         if (ceM)
            mM = prodModel(preModel(mA, mD, mInMode), mB);
         if (ceC)
            mC = c;
         if (ceA)
            mA = a;
         if (ceB)
            mB = b;
         if (ceD)
            mD = d;
         if (ceCtrl) begin
            mInMode = inMode;
            mOpMode = opMode;
            mAlu = aluMode;
            mCarryIn = carryIn;
         end
      end
   end

   // invalid when the product is picked by exactly one of x and y.
   always @(negedge CLK) begin
      checkValue("opModeInvalid", 48'(opModeInvalid),
                 48'(((mOpMode[1:0] == dspPkg::xMult) +
                      (mOpMode[3:2] == dspPkg::yMult)) == 1));
      if (mPValid) begin
         checkValue("p", p, mP);
         checkValue("carryOut", 48'(carryOut), 48'(mCarryOut));
         checkValue("patternDetect", 48'(patternDetect), 48'(mPat));
         checkValue("patternBDetect", 48'(patternBDetect), 48'(mPatB));
      end
   end

   always @(posedge CLK) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("Timeout: run did not finish within %0d cycles", cycleLimit);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   always @(DUT.chk.errCount) begin
      if (DUT.chk.errCount != 0) begin
         $display("A bound checker assertion on the DUT failed");
         $display("Test failed");
         $fatal(1, "checker assertion");
      end
   end

   task automatic driveOp(input int phase);
      logic [47:0] opC, opPcIn, want;
      logic [3:0]  opAlu;
      logic [1:0]  xs, ys;
      logic [2:0]  zs, im;
      opC = rand48();
      opPcIn = rand48();
      im = 3'($urandom());
      opAlu = dspPkg::aluAdd;
      xs = dspPkg::xMult;
      ys = dspPkg::yMult;
      zs = dspPkg::zZero;
      case (phase)
         0: begin
            xs = dspPkg::xZero;
            ys = dspPkg::yZero;
         end
         1: begin
            im[0] = 1'b0;
            zs = dspPkg::zP;
         end
         2: zs = dspPkg::zZero;
         3: begin
            xs = $urandom_range(1) ? dspPkg::xAB : dspPkg::xP;
            ys = $urandom_range(1) ? dspPkg::yC : dspPkg::yOnes;
            zs = $urandom_range(1) ? dspPkg::zC : dspPkg::zPcIn;
            opAlu = $urandom_range(1) ? dspPkg::aluZMinus : dspPkg::aluAdd;
         end
         4: begin
            ys = dspPkg::yZero;
            xs = $urandom_range(1) ? dspPkg::xAB : dspPkg::xP;
            zs = $urandom_range(1) ? dspPkg::zC : dspPkg::zPcIn;
            case ($urandom_range(2))
               0: opAlu = dspPkg::aluXor;
               1: opAlu = dspPkg::aluAnd;
               default: opAlu = dspPkg::aluOr;
            endcase
            if ($urandom_range(2) == 0) begin
               // result is pcIn or zero here, so c can be steered onto it.
               xs = dspPkg::xZero;
               zs = dspPkg::zPcIn;
               want = (opAlu == dspPkg::aluAnd) ? 48'd0 : opPcIn;
               opC = ($urandom_range(1) ? want : ~want) ^ 48'($urandom_range(15));
            end
         end
         5: zs = $urandom_range(1) ? dspPkg::zPShift : dspPkg::zPcInShift;
         default: begin
            xs = 2'($urandom());
            ys = 2'($urandom());
            zs = 3'($urandom());
            opAlu = 4'($urandom());
         end
      endcase
      {ceA, ceB, ceC, ceD, ceM, ceP, ceCtrl} <=
         (phase == 6) ? (7'($urandom()) | 7'($urandom())) : 7'h7F;
      a <= 30'($urandom());
      b <= 18'($urandom());
      d <= 25'($urandom());
      inMode <= im;
      c <= nextC;
      opMode <= nextOpMode;
      aluMode <= nextAlu;
      carryIn <= nextCarry;
      pcIn <= pcInLate;
      nextC = opC;
      nextOpMode = {zs, ys, xs};
      nextAlu = opAlu;
      nextCarry = (phase == 3 || phase == 6) ? 1'($urandom()) : 1'b0;
      pcInLate = pcInMid;
      pcInMid = opPcIn;
   endtask

   initial begin
      void'($urandom(32'heb1e_3a1e));
      rstN <= 1'b0;
      {a, b, d, c, pcIn} = '0;
      {inMode, opMode, aluMode, carryIn} = '0;
      {ceA, ceB, ceC, ceD, ceM, ceP, ceCtrl} = '1;
      {nextC, pcInMid, pcInLate, nextOpMode, nextAlu, nextCarry} = '0;
      repeat (10) @(posedge CLK);
      rstN <= 1'b1;
      for (int phase = 1; phase <= 6; phase++) begin
         repeat (300) begin
            @(posedge CLK);
            driveOp(phase);
         end
      end
      // drain the last operations out of the pipeline.
      repeat (4) begin
         @(posedge CLK);
         driveOp(0);
      end
      @(negedge CLK);
      if (DUT.chk.errCount == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1, "checker assertions failed");
      end
   end

endmodule

`default_nettype wire

//--- dv/dspSlice_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dspSliceChk (
   input wire                       CLK,
   input wire                       rstN,
   input wire                       ceP,
   input wire dspPkg::aluOpE        aluOp,
   input wire [dspPkg::pWidth-1:0]  p,
   input wire                       carryOut,
   input wire                       patternDetect,
   input wire                       patternBDetect
);

   int  errCount = 0;
   wire logicOp;

   assign logicOp = (aluOp == dspPkg::aluXor) || (aluOp == dspPkg::aluAnd) ||
                    (aluOp == dspPkg::aluOr);

   resetClear: assert property (@(posedge CLK)
      !rstN |-> (p == '0 && !carryOut && !patternDetect && !patternBDetect))
      else begin
         errCount++;
         $error("p or a flag is set during reset");
      end

   // p and its carry freeze with the enable.
   pHold: assert property (@(posedge CLK) disable iff (!rstN)
      !ceP |=> ($stable(p) && $stable(carryOut)))
      else begin
         errCount++;
         $error("p or carryOut changed with ceP low");
      end

   flagsExclusive: assert property (@(posedge CLK)
      !(patternDetect && patternBDetect) || (dspPkg::patternMask == '1))
      else begin
         errCount++;
         $error("patternDetect and patternBDetect both high");
      end

   logicNoCarry: assert property (@(posedge CLK) disable iff (!rstN)
      (ceP && logicOp) |=> !carryOut)
      else begin
         errCount++;
         $error("carryOut set after a logic operation");
      end

endmodule

bind dspSlice dspSliceChk chk (
   .CLK(CLK), .rstN(rstN), .ceP(ceP), .aluOp(aluOp), .p(p),
   .carryOut(carryOut), .patternDetect(patternDetect), .patternBDetect(patternBDetect)
);

`default_nettype wire

//--- verilog/dspSlice.sv
`timescale 1ns/1ps
`default_nettype none

module dspSlice (
   input  wire                            CLK,
   input  wire                            rstN,
   input  wire  [dspPkg::aWidth-1:0]      a,
   input  wire  [dspPkg::bWidth-1:0]      b,
   input  wire  [dspPkg::cWidth-1:0]      c,
   input  wire  [dspPkg::dWidth-1:0]      d,
   input  wire  [dspPkg::pWidth-1:0]      pcIn,
   input  wire  [2:0]                     inMode,
   input  wire  [6:0]                     opMode,
   input  wire  [3:0]                     aluMode,
   input  wire                            carryIn,
   input  wire                            ceA,
   input  wire                            ceB,
   input  wire                            ceC,
   input  wire                            ceD,
   input  wire                            ceM,
   input  wire                            ceP,
   input  wire                            ceCtrl,
   output wire  [dspPkg::pWidth-1:0]      p,
   output wire                            carryOut,
   output wire                            patternDetect,
   output wire                            patternBDetect,
   output wire                            opModeInvalid
);

   wire dspPkg::preOpE             preOp;
   wire dspPkg::xSelE              xSel;
   wire dspPkg::ySelE              ySel;
   wire dspPkg::zSelE              zSel;
   wire dspPkg::aluOpE             aluOp;
   wire                            carryInR;
   wire [dspPkg::aWidth-1:0]       aReg;
   wire [dspPkg::bWidth-1:0]       bReg;
   wire [dspPkg::cWidth-1:0]       cReg;
   wire [dspPkg::preWidth-1:0]     preOut;
   wire [dspPkg::prodWidth-1:0]    mReg;
   wire [dspPkg::pWidth-1:0]       x;
   wire [dspPkg::pWidth-1:0]       y;
   wire [dspPkg::pWidth-1:0]       z;

   dspCtrl ctrl (
      .CLK(CLK), .rstN(rstN), .ceCtrl(ceCtrl),
      .inMode(inMode), .opMode(opMode), .aluMode(aluMode), .carryIn(carryIn),
      .preOp(preOp), .xSel(xSel), .ySel(ySel), .zSel(zSel), .aluOp(aluOp),
      .carryInR(carryInR), .opModeInvalid(opModeInvalid)
   );

   preAdder preAdd (
      .CLK(CLK), .rstN(rstN), .ceA(ceA), .ceD(ceD),
      .a(a), .d(d), .preOp(preOp), .aReg(aReg), .preOut(preOut)
   );

   multStage mult (
      .CLK(CLK), .rstN(rstN), .ceB(ceB), .ceM(ceM),
      .b(b), .preOut(preOut), .bReg(bReg), .mReg(mReg)
   );

   operandMux opMux (
      .CLK(CLK), .rstN(rstN), .ceC(ceC), .c(c), .pcIn(pcIn),
      .mReg(mReg), .aReg(aReg), .bReg(bReg), .p(p),
      .xSel(xSel), .ySel(ySel), .zSel(zSel),
      .x(x), .y(y), .z(z), .cReg(cReg)
   );

   dspAlu alu (
      .CLK(CLK), .rstN(rstN), .ceP(ceP), .x(x), .y(y), .z(z), .cReg(cReg),
      .aluOp(aluOp), .carryInR(carryInR), .p(p), .carryOut(carryOut),
      .patternDetect(patternDetect), .patternBDetect(patternBDetect)
   );

endmodule

`default_nettype wire

//--- verilog/dspAlu.sv
`timescale 1ns/1ps
`default_nettype none

module dspAlu (
   input  wire                            CLK,
   input  wire                            rstN,
   input  wire                            ceP,
   input  wire  [dspPkg::pWidth-1:0]      x,
   input  wire  [dspPkg::pWidth-1:0]      y,
   input  wire  [dspPkg::pWidth-1:0]      z,
   input  wire  [dspPkg::cWidth-1:0]      cReg,
   input  wire  dspPkg::aluOpE            aluOp,
   input  wire                            carryInR,
   output logic [dspPkg::pWidth-1:0]      p,
   output logic                           carryOut,
   output logic                           patternDetect,
   output logic                           patternBDetect
);

   logic [dspPkg::pWidth:0]   xyc;
   logic [dspPkg::pWidth:0]   aluSum;
   logic [dspPkg::pWidth-1:0] result;
   logic                      carryNext;
   logic                      patNext;
   logic                      patBNext;

   // x + y + carry, one bit wider for the carry out.
   assign xyc = {1'b0, x} + {1'b0, y} + {{dspPkg::pWidth{1'b0}}, carryInR};

   always_comb begin
      aluSum    = '0;
      carryNext = 1'b0;
      case (aluOp)
         dspPkg::aluZMinus: begin
            aluSum    = {1'b0, z} - xyc;
            result    = aluSum[dspPkg::pWidth-1:0];
            carryNext = aluSum[dspPkg::pWidth];
         end
         dspPkg::aluXor: result = x ^ z;
         dspPkg::aluAnd: result = x & z;
         dspPkg::aluOr:  result = x | z;
         default: begin
            aluSum    = {1'b0, z} + xyc;
            result    = aluSum[dspPkg::pWidth-1:0];
            carryNext = aluSum[dspPkg::pWidth];
         end
      endcase
   end

   // masked compare against c and its complement.
   assign patNext  = ((result ^ cReg) & ~dspPkg::patternMask) == '0;
   assign patBNext = ((result ^ ~cReg) & ~dspPkg::patternMask) == '0;

   // flags ride with p so they always describe it.
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         p              <= '0;
         carryOut       <= 1'b0;
         patternDetect  <= 1'b0;
         patternBDetect <= 1'b0;
      end else if (ceP) begin
         p              <= result;
         carryOut       <= carryNext;
         patternDetect  <= patNext;
         patternBDetect <= patBNext;
      end
   end

endmodule

`default_nettype wire

//--- verilog/operandMux.sv
`timescale 1ns/1ps
`default_nettype none

module operandMux (
   input  wire                            CLK,
   input  wire                            rstN,
   input  wire                            ceC,
   input  wire  [dspPkg::cWidth-1:0]      c,
   input  wire  [dspPkg::pWidth-1:0]      pcIn,
   input  wire  [dspPkg::prodWidth-1:0]   mReg,
   input  wire  [dspPkg::aWidth-1:0]      aReg,
   input  wire  [dspPkg::bWidth-1:0]      bReg,
   input  wire  [dspPkg::pWidth-1:0]      p,
   input  wire  dspPkg::xSelE             xSel,
   input  wire  dspPkg::ySelE             ySel,
   input  wire  dspPkg::zSelE             zSel,
   output logic [dspPkg::pWidth-1:0]      x,
   output logic [dspPkg::pWidth-1:0]      y,
   output logic [dspPkg::pWidth-1:0]      z,
   output logic [dspPkg::cWidth-1:0]      cReg
);

   localparam int extBits = dspPkg::pWidth - dspPkg::prodWidth;

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         cReg <= '0;
      end else if (ceC) begin
         cReg <= c;
      end
   end

   always_comb begin
      case (xSel)
         dspPkg::xMult: x = {{extBits{mReg[dspPkg::prodWidth-1]}}, mReg};
         dspPkg::xP:    x = p;
         dspPkg::xAB:   x = {aReg, bReg};
         default:       x = '0;
      endcase
   end

   // the whole product sits on x, so yMult adds nothing.
   always_comb begin
      case (ySel)
         dspPkg::yOnes: y = '1;
         dspPkg::yC:    y = cReg;
         default:       y = '0;
      endcase
   end

   // shifted forms keep the sign for wide accumulation.
   always_comb begin
      case (zSel)
         dspPkg::zPcIn:      z = pcIn;
         dspPkg::zP:         z = p;
         dspPkg::zC:         z = cReg;
         dspPkg::zPcInShift: z = $signed(pcIn) >>> dspPkg::zShift;
         dspPkg::zPShift:    z = $signed(p) >>> dspPkg::zShift;
         default:            z = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/multStage.sv
`timescale 1ns/1ps
`default_nettype none

module multStage (
   input  wire                            CLK,
   input  wire                            rstN,
   input  wire                            ceB,
   input  wire                            ceM,
   input  wire  [dspPkg::bWidth-1:0]      b,
   input  wire  [dspPkg::preWidth-1:0]    preOut,
   output logic [dspPkg::bWidth-1:0]      bReg,
   output logic [dspPkg::prodWidth-1:0]   mReg
);

   logic signed [dspPkg::prodWidth-1:0] product;

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         bReg <= '0;
      end else if (ceB) begin
         bReg <= b;
      end
   end

   // full signed 25x18 product, no partial products.
   assign product = $signed(preOut) * $signed(bReg);

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         mReg <= '0;
      end else if (ceM) begin
         mReg <= product;
      end
   end

endmodule

`default_nettype wire

//--- verilog/preAdder.sv
`timescale 1ns/1ps
`default_nettype none

module preAdder (
   input  wire                            CLK,
   input  wire                            rstN,
   input  wire                            ceA,
   input  wire                            ceD,
   input  wire  [dspPkg::aWidth-1:0]      a,
   input  wire  [dspPkg::dWidth-1:0]      d,
   input  wire  dspPkg::preOpE            preOp,
   output logic [dspPkg::aWidth-1:0]      aReg,
   output logic [dspPkg::preWidth-1:0]    preOut
);

   logic [dspPkg::dWidth-1:0]   dReg;
   logic [dspPkg::preWidth-1:0] aLow;

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         aReg <= '0;
      end else if (ceA) begin
         aReg <= a;
      end
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         dReg <= '0;
      end else if (ceD) begin
         dReg <= d;
      end
   end

   // only the low 25 bits of a reach the multiplier.
   assign aLow = aReg[dspPkg::preWidth-1:0];

   // wraps at 25 bits like the hard pre-adder.
   always_comb begin
      case (preOp)
         dspPkg::preDPlusA:  preOut = dReg + aLow;
         dspPkg::preDMinusA: preOut = dReg - aLow;
         dspPkg::preD:       preOut = dReg;
         dspPkg::preZero:    preOut = '0;
         default:            preOut = aLow;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/dspCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module dspCtrl (
   input  wire               CLK,
   input  wire               rstN,
   input  wire               ceCtrl,
   input  wire  [2:0]        inMode,
   input  wire  [6:0]        opMode,
   input  wire  [3:0]        aluMode,
   input  wire               carryIn,
   output dspPkg::preOpE     preOp,
   output dspPkg::xSelE      xSel,
   output dspPkg::ySelE      ySel,
   output dspPkg::zSelE      zSel,
   output dspPkg::aluOpE     aluOp,
   output logic              carryInR,
   output logic              opModeInvalid
);

   logic [2:0] inModeR;
   logic [6:0] opModeR;
   logic [3:0] aluModeR;

   // inMode lines up with the a, b and d registers.
   // the rest lines up with m and c, one cycle later.
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         inModeR  <= '0;
         opModeR  <= '0;
         aluModeR <= '0;
         carryInR <= 1'b0;
      end else if (ceCtrl) begin
         inModeR  <= inMode;
         opModeR  <= opMode;
         aluModeR <= aluMode;
         carryInR <= carryIn;
      end
   end

   // bit 0 gates a, bit 1 enables d, bit 2 subtracts.
   always_comb begin
      if (inModeR[0]) begin
         preOp = inModeR[1] ? dspPkg::preD : dspPkg::preZero;
      end else if (inModeR[1]) begin
         preOp = inModeR[2] ? dspPkg::preDMinusA : dspPkg::preDPlusA;
      end else begin
         preOp = dspPkg::preA;
      end
   end

   assign xSel = dspPkg::xSelE'(opModeR[1:0]);
   assign ySel = dspPkg::ySelE'(opModeR[3:2]);

   always_comb begin
      case (opModeR[6:4])
         3'd1:    zSel = dspPkg::zPcIn;
         3'd2:    zSel = dspPkg::zP;
         3'd3:    zSel = dspPkg::zC;
         3'd5:    zSel = dspPkg::zPcInShift;
         3'd6:    zSel = dspPkg::zPShift;
         default: zSel = dspPkg::zZero;
      endcase
   end

   always_comb begin
      case (aluModeR)
         4'b0011: aluOp = dspPkg::aluZMinus;
         4'b0100: aluOp = dspPkg::aluXor;
         4'b1100: aluOp = dspPkg::aluAnd;
         4'b1110: aluOp = dspPkg::aluOr;
         default: aluOp = dspPkg::aluAdd;
      endcase
   end

   // product must sit on both x and y or on neither.
   assign opModeInvalid = (xSel == dspPkg::xMult) != (ySel == dspPkg::yMult);

endmodule

`default_nettype wire

//--- verilog/dspPkg.sv
`default_nettype none

package dspPkg;

   // input port widths.
   localparam int aWidth = 30;
   localparam int bWidth = 18;
   localparam int cWidth = 48;
   localparam int dWidth = 25;

   // multiplier operand and product widths.
   localparam int preWidth  = 25;
   localparam int prodWidth = 43;

   // alu operands and p.
   localparam int pWidth = 48;

   // arithmetic right shift applied to wide z operands.
   localparam int zShift = 17;

   // ones mark bits the pattern compare ignores.
   localparam logic [pWidth-1:0] patternMask = 48'h0000_0000_000F;

   typedef enum logic [2:0] {
      preA       = 3'd0,
      preDPlusA  = 3'd1,
      preDMinusA = 3'd2,
      preD       = 3'd3,
      preZero    = 3'd4
   } preOpE;

   typedef enum logic [1:0] {
      xZero = 2'd0,
      xMult = 2'd1,
      xP    = 2'd2,
      xAB   = 2'd3
   } xSelE;

   typedef enum logic [1:0] {
      yZero = 2'd0,
      yMult = 2'd1,
      yOnes = 2'd2,
      yC    = 2'd3
   } ySelE;

   // codes 4 and 7 are unused.
   typedef enum logic [2:0] {
      zZero      = 3'd0,
      zPcIn      = 3'd1,
      zP         = 3'd2,
      zC         = 3'd3,
      zPcInShift = 3'd5,
      zPShift    = 3'd6
   } zSelE;

   typedef enum logic [3:0] {
      aluAdd    = 4'b0000,
      aluZMinus = 4'b0011,
      aluXor    = 4'b0100,
      aluAnd    = 4'b1100,
      aluOr     = 4'b1110
   } aluOpE;

endpackage

`default_nettype wire
